/* design/rename_pkg.sv */
package rename_pkg;

    localparam int xlen      = 32;
    localparam int tag_w     = 4;
    localparam int reg_count = 32;

    typedef logic [4:0] reg_name_t;

    typedef enum logic [3:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        lui,
        auipc,
        jal,
        jalr,
        illegal
    } op_class_e;

    // Instruction formats, msb first.
    typedef struct packed {
        logic [6:0] funct7;
        reg_name_t  rs2;
        reg_name_t  rs1;
        logic [2:0] funct3;
        reg_name_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_name_t   rs1;
        logic [2:0]  funct3;
        reg_name_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_name_t  rs2;
        reg_name_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_name_t  rs2;
        reg_name_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_name_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_name_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_u;

    typedef struct packed {
        op_class_e        op_class;
        logic [2:0]       funct3;
        logic             funct7_b5;
        reg_name_t        rs1;
        reg_name_t        rs2;
        reg_name_t        rd;
        logic             has_rd;
        logic             uses_rs1;
        logic             uses_rs2;
        logic [xlen-1:0]  imm;
    } decoded_inst_t;

    typedef struct packed {
        logic [xlen-1:0]  value;
        logic [tag_w-1:0] tag;
        logic             ready;
    } src_operand_t;

    typedef struct packed {
        logic             valid;
        reg_name_t        rd;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } commit_t;

    typedef struct packed {
        op_class_e        op_class;
        logic [2:0]       funct3;
        logic             funct7_b5;
        reg_name_t        rd;
        logic [tag_w-1:0] rd_tag;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  imm;
        src_operand_t     rs1;
        src_operand_t     rs2;
    } dispatch_entry_t;

endpackage

/* design/inst_decoder.sv */
module inst_decoder (
    input  rename_pkg::inst_word_u    inst,
    output rename_pkg::decoded_inst_t dec
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    logic [rename_pkg::xlen-1:0] imm_i;
    logic [rename_pkg::xlen-1:0] imm_s;
    logic [rename_pkg::xlen-1:0] imm_b;
    logic [rename_pkg::xlen-1:0] imm_u;
    logic [rename_pkg::xlen-1:0] imm_j;

    // All five immediates from the same word, each via its own view.
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    always_comb begin
        dec.funct3    = inst.r.funct3;
        dec.funct7_b5 = inst.r.funct7[5];
        dec.rs1       = inst.r.rs1;
        dec.rs2       = inst.r.rs2;
        dec.rd        = inst.r.rd;

        dec.op_class  = rename_pkg::illegal;
        dec.has_rd    = 1'b0;
        dec.uses_rs1  = 1'b0;
        dec.uses_rs2  = 1'b0;
        dec.imm       = '0;

        case (inst.r.opcode)
            opc_op: begin
                dec.op_class = rename_pkg::alu_reg;
                dec.has_rd   = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            opc_op_imm: begin
                dec.op_class = rename_pkg::alu_imm;
                dec.has_rd   = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.imm      = imm_i;
            end
            opc_load: begin
                dec.op_class = rename_pkg::load;
                dec.has_rd   = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.imm      = imm_i;
            end
            opc_store: begin
                dec.op_class = rename_pkg::store;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = imm_s;
            end
            opc_branch: begin
                dec.op_class = rename_pkg::branch;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = imm_b;
            end
            opc_lui: begin
                dec.op_class = rename_pkg::lui;
                dec.has_rd   = 1'b1;
                dec.imm      = imm_u;
            end
            opc_auipc: begin
                dec.op_class = rename_pkg::auipc;
                dec.has_rd   = 1'b1;
                dec.imm      = imm_u;
            end
            opc_jal: begin
                dec.op_class = rename_pkg::jal;
                dec.has_rd   = 1'b1;
                dec.imm      = imm_j;
            end
            opc_jalr: begin
                dec.op_class = rename_pkg::jalr;
                dec.has_rd   = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.imm      = imm_i;
            end
            default: begin
                // Unknown opcode, nothing read or written.
                dec.op_class = rename_pkg::illegal;
            end
        endcase
    end

endmodule

/* design/rename_regfile.sv */
module rename_regfile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rdy,
    input  logic                               clr,
    input  logic                               alloc_en,
    input  rename_pkg::decoded_inst_t          dec,
    input  logic [rename_pkg::tag_w-1:0]       alloc_tag,
    input  rename_pkg::commit_t                commit,
    output rename_pkg::src_operand_t           rs1_raw,
    output rename_pkg::src_operand_t           rs2_raw
);

    logic [rename_pkg::xlen-1:0]  vals [rename_pkg::reg_count];
    logic [rename_pkg::tag_w-1:0] tags [rename_pkg::reg_count];

    logic commit_hit;
    logic alloc_hit;

    // Register zero is never a target.
    assign commit_hit = commit.valid && (commit.rd != '0);
    assign alloc_hit  = alloc_en && dec.has_rd && (dec.rd != '0);

    function automatic rename_pkg::src_operand_t read_src(
        input rename_pkg::reg_name_t        name,
        input logic [rename_pkg::xlen-1:0]  val,
        input logic [rename_pkg::tag_w-1:0] tag
    );
        rename_pkg::src_operand_t op;
        if (name == '0) begin
            op.value = '0;
            op.tag   = '0;
        end else begin
            op.value = val;
            op.tag   = tag;
        end
        op.ready = (op.tag == '0);
        return op;
    endfunction

    // Reads see the state before the edge.
    assign rs1_raw = read_src(dec.rs1, vals[dec.rs1], tags[dec.rs1]);
    assign rs2_raw = read_src(dec.rs2, vals[dec.rs2], tags[dec.rs2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::reg_count; i++) begin
                vals[i] <= '0;
                tags[i] <= '0;
            end
        end else if (rdy || clr) begin
            if (commit_hit) begin
                vals[commit.rd] <= commit.value;
                // Only the latest producer may release the register.
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end

            // Later assignments win over the commit release.
            if (clr) begin
                for (int i = 0; i < rename_pkg::reg_count; i++) begin
                    tags[i] <= '0;
                end
            end else if (alloc_hit) begin
                tags[dec.rd] <= alloc_tag;
            end
        end
    end

endmodule

/* design/dispatch_merge.sv */
module dispatch_merge (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rdy,
    input  logic                               clr,
    input  logic                               accept,
    input  rename_pkg::decoded_inst_t          dec,
    input  logic [rename_pkg::xlen-1:0]        pc,
    input  logic [rename_pkg::tag_w-1:0]       alloc_tag,
    input  rename_pkg::src_operand_t           rs1_raw,
    input  rename_pkg::src_operand_t           rs2_raw,
    input  rename_pkg::commit_t                commit,
    output logic                               dispatch_valid,
    output rename_pkg::dispatch_entry_t        entry
);

    rename_pkg::dispatch_entry_t entry_next;

    function automatic rename_pkg::src_operand_t resolve(
        input rename_pkg::src_operand_t raw,
        input logic                     used,
        input rename_pkg::commit_t      c
    );
        rename_pkg::src_operand_t op;
        op = raw;
        if (!used) begin
            op.value = '0;
            op.tag   = '0;
            op.ready = 1'b1;
        end else if (c.valid && (raw.tag != '0) && (raw.tag == c.tag)) begin
            // Producer commits this cycle.
            op.value = c.value;
            op.tag   = '0;
            op.ready = 1'b1;
        end
        return op;
    endfunction

    always_comb begin
        entry_next.op_class  = dec.op_class;
        entry_next.funct3    = dec.funct3;
        entry_next.funct7_b5 = dec.funct7_b5;
        entry_next.rd        = dec.rd;
        entry_next.rd_tag    = (dec.has_rd && dec.rd != '0) ? alloc_tag : '0;
        entry_next.pc        = pc;
        entry_next.imm       = dec.imm;
        entry_next.rs1       = resolve(rs1_raw, dec.uses_rs1, commit);
        entry_next.rs2       = resolve(rs2_raw, dec.uses_rs2, commit);
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            dispatch_valid <= 1'b0;
        end else if (rdy) begin
            dispatch_valid <= accept;
        end
    end

    // Entry keeps the last dispatched instruction.
    always_ff @(posedge clk) begin
        if (rst) begin
            entry <= '0;
        end else if (accept) begin
            entry <= entry_next;
        end
    end

endmodule

/* design/rename_stage.sv */
module rename_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rdy,
    input  logic                               clr,
    input  logic                               inst_valid,
    input  rename_pkg::inst_word_u             inst,
    input  logic [rename_pkg::xlen-1:0]        pc,
    input  logic [rename_pkg::tag_w-1:0]       alloc_tag,
    input  rename_pkg::commit_t                commit,
    output logic                               dispatch_valid,
    output rename_pkg::dispatch_entry_t        entry
);

    rename_pkg::decoded_inst_t dec;
    rename_pkg::src_operand_t  rs1_raw;
    rename_pkg::src_operand_t  rs2_raw;
    logic                      accept;

    // Taken only while the stage is not frozen.
    assign accept = inst_valid && rdy;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    rename_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .clr       (clr),
        .alloc_en  (accept),
        .dec       (dec),
        .alloc_tag (alloc_tag),
        .commit    (commit),
        .rs1_raw   (rs1_raw),
        .rs2_raw   (rs2_raw)
    );

    dispatch_merge u_merge (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .clr            (clr),
        .accept         (accept),
        .dec            (dec),
        .pc             (pc),
        .alloc_tag      (alloc_tag),
        .rs1_raw        (rs1_raw),
        .rs2_raw        (rs2_raw),
        .commit         (commit),
        .dispatch_valid (dispatch_valid),
        .entry          (entry)
    );

endmodule

/* sim/rename_stage_sva.sv */
module rename_stage_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        rdy,
    input logic                        clr,
    input logic                        dispatch_valid,
    input rename_pkg::dispatch_entry_t entry
);

    // No dispatch right after reset or flush.
    assert property (@(posedge clk) (rst || clr) |=> !dispatch_valid)
        else $error("dispatch_valid high after reset or flush");

    // Frozen stage keeps its entry.
    assert property (@(posedge clk) disable iff (rst) !rdy |=> $stable(entry))
        else $error("entry changed while rdy was low");

    assert property (@(posedge clk) disable iff (rst)
                     entry.rs1.ready |-> entry.rs1.tag == '0)
        else $error("rs1 ready with a nonzero tag");

    assert property (@(posedge clk) disable iff (rst)
                     entry.rs2.ready |-> entry.rs2.tag == '0)
        else $error("rs2 ready with a nonzero tag");

endmodule

bind rename_stage rename_stage_sva sva0 (
    .clk            (clk),
    .rst            (rst),
    .rdy            (rdy),
    .clr            (clr),
    .dispatch_valid (dispatch_valid),
    .entry          (entry)
);

/* sim/rename_stage_tb.sv */
module rename_stage_tb;

    logic                        clk;
    logic                        rst;
    logic                        rdy;
    logic                        clr;
    logic                        inst_valid;
    rename_pkg::inst_word_u      inst;
    logic [31:0]                 pc;
    logic [3:0]                  alloc_tag;
    rename_pkg::commit_t         commit;
    logic                        dispatch_valid;
    rename_pkg::dispatch_entry_t entry;

    // Reference state of the architectural registers.
    logic [31:0] m_val [32];
    logic [3:0]  m_tag [32];

    int     errors;
    int     timeouts;
    integer seed;

    rename_stage dut0 (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .clr            (clr),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .alloc_tag      (alloc_tag),
        .commit         (commit),
        .dispatch_valid (dispatch_valid),
        .entry          (entry)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic rename_pkg::commit_t make_commit(input logic [4:0] rd,
                                                        input logic [3:0] tag,
                                                        input logic [31:0] value);
        rename_pkg::commit_t c;
        c.valid = 1'b1;
        c.rd    = rd;
        c.tag   = tag;
        c.value = value;
        return c;
    endfunction

    // Operand as the reservation station should see it.
    function automatic rename_pkg::src_operand_t expect_src(input logic [4:0] r,
                                                            input logic used,
                                                            input rename_pkg::commit_t c);
        rename_pkg::src_operand_t op;
        op.value = '0;
        op.tag   = '0;
        op.ready = 1'b1;
        if (used && r != 5'd0) begin
            if (c.valid && m_tag[r] != 4'd0 && m_tag[r] == c.tag) begin
                op.value = c.value;
            end else begin
                op.value = m_val[r];
                op.tag   = m_tag[r];
                op.ready = (m_tag[r] == 4'd0);
            end
        end
        return op;
    endfunction

    task automatic model_edge(input rename_pkg::commit_t c, input logic alloc,
                              input logic [4:0] rd, input logic [3:0] t);
        if (c.valid && c.rd != 5'd0) begin
            m_val[c.rd] = c.value;
            if (m_tag[c.rd] == c.tag) begin
                m_tag[c.rd] = 4'd0;
            end
        end
        if (alloc && rd != 5'd0) begin
            m_tag[rd] = t;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_src(input string name, input rename_pkg::src_operand_t got,
                             input rename_pkg::src_operand_t exp);
        check_val({name, ".value"}, got.value, exp.value);
        check_val({name, ".tag"}, 32'(got.tag), 32'(exp.tag));
        check_val({name, ".ready"}, 32'(got.ready), 32'(exp.ready));
    endtask

    task automatic wait_dispatch(output int waited);
        waited = 0;
        @(negedge clk);
        while (!dispatch_valid && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!dispatch_valid) begin
            timeouts++;
            $display("Timed out waiting for dispatch_valid");
        end
    endtask

    task automatic commit_only(input logic [4:0] rd, input logic [3:0] tag,
                               input logic [31:0] value);
        rename_pkg::commit_t c;
        c = make_commit(rd, tag, value);
        @(posedge clk);
        commit <= c;
        @(posedge clk);
        commit <= '0;
        model_edge(c, 1'b0, 5'd0, 4'd0);
    endtask

    task automatic issue(input logic [31:0] w, input logic [31:0] p, input logic [3:0] t,
                         input rename_pkg::commit_t c, input rename_pkg::op_class_e cls,
                         input logic has_rd, input logic u1, input logic u2,
                         input logic [31:0] imm);
        rename_pkg::src_operand_t e1;
        rename_pkg::src_operand_t e2;
        logic [3:0]               e_tag;
        int                       waited;
        e1    = expect_src(w[19:15], u1, c);
        e2    = expect_src(w[24:20], u2, c);
        e_tag = (has_rd && w[11:7] != 5'd0) ? t : 4'd0;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        pc         <= p;
        alloc_tag  <= t;
        commit     <= c;
        @(negedge clk);
        check_val("dispatch_valid before accept", 32'(dispatch_valid), 32'd0);
        @(posedge clk);
        inst_valid <= 1'b0;
        commit     <= '0;
        model_edge(c, has_rd, w[11:7], t);
        wait_dispatch(waited);
        check_val("dispatch latency", 32'(waited), 32'd0);
        check_val("entry.op_class", 32'(entry.op_class), 32'(cls));
        check_val("entry.funct3", 32'(entry.funct3), 32'(w[14:12]));
        check_val("entry.funct7_b5", 32'(entry.funct7_b5), 32'(w[30]));
        check_val("entry.rd", 32'(entry.rd), 32'(w[11:7]));
        check_val("entry.rd_tag", 32'(entry.rd_tag), 32'(e_tag));
        check_val("entry.pc", entry.pc, p);
        check_val("entry.imm", entry.imm, imm);
        check_src("entry.rs1", entry.rs1, e1);
        check_src("entry.rs2", entry.rs2, e2);
    endtask

    task automatic test_reset_read();
        issue(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd5), 32'h100, 4'd1, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
    endtask

    task automatic test_commit_values();
        commit_only(5'd3, 4'd0, $random(seed));
        commit_only(5'd4, 4'd0, $random(seed));
        commit_only(5'd5, 4'd0, $random(seed));
        commit_only(5'd0, 4'd0, $random(seed));
        issue(enc_r(7'd0, 5'd4, 5'd3, 3'd0, 5'd6), 32'h104, 4'd2, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
        // x0 must stay zero after the commit above.
        issue(enc_r(7'h20, 5'd0, 5'd5, 3'd0, 5'd20), 32'h108, 4'd3, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
    endtask

    task automatic test_pending_tag();
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'b0010011), 32'h10c, 4'd5, '0,
              rename_pkg::alu_imm, 1'b1, 1'b1, 1'b0, 32'd1);
        issue(enc_r(7'd0, 5'd0, 5'd7, 3'd0, 5'd8), 32'h110, 4'd9, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
        // Stale producer, value lands but x7 stays pending.
        commit_only(5'd7, 4'd3, $random(seed));
        issue(enc_r(7'd0, 5'd0, 5'd7, 3'd0, 5'd8), 32'h114, 4'd10, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
        commit_only(5'd7, 4'd5, $random(seed));
        issue(enc_r(7'd0, 5'd0, 5'd7, 3'd0, 5'd8), 32'h118, 4'd11, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
    endtask

    task automatic test_commit_bypass();
        issue(enc_i(12'd4, 5'd3, 3'd0, 5'd9, 7'b0010011), 32'h11c, 4'd6, '0,
              rename_pkg::alu_imm, 1'b1, 1'b1, 1'b0, 32'd4);
        issue(enc_r(7'd0, 5'd9, 5'd9, 3'd0, 5'd10), 32'h120, 4'd12,
              make_commit(5'd9, 4'd6, $random(seed)),
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
    endtask

    task automatic test_formats();
        issue(enc_i(12'hfec, 5'd1, 3'd0, 5'd21, 7'b0010011), 32'h200, 4'd1, '0,
              rename_pkg::alu_imm, 1'b1, 1'b1, 1'b0, 32'hffffffec);
        issue(enc_i(12'h07f, 5'd2, 3'd2, 5'd22, 7'b0000011), 32'h204, 4'd2, '0,
              rename_pkg::load, 1'b1, 1'b1, 1'b0, 32'h0000007f);
        // Store and branch rd fields name x24 and x17, which must stay free.
        issue(enc_s(12'hff8, 5'd3, 5'd2, 3'd2), 32'h208, 4'd13, '0,
              rename_pkg::store, 1'b0, 1'b1, 1'b1, 32'hfffffff8);
        issue(enc_b(13'h1ff0, 5'd4, 5'd3, 3'd0), 32'h20c, 4'd14, '0,
              rename_pkg::branch, 1'b0, 1'b1, 1'b1, 32'hfffffff0);
        issue(enc_r(7'd0, 5'd17, 5'd24, 3'd0, 5'd25), 32'h210, 4'd3, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
        issue({20'habcde, 5'd26, 7'b0110111}, 32'h214, 4'd4, '0,
              rename_pkg::lui, 1'b1, 1'b0, 1'b0, 32'habcde000);
        issue({20'h00001, 5'd29, 7'b0010111}, 32'h218, 4'd5, '0,
              rename_pkg::auipc, 1'b1, 1'b0, 1'b0, 32'h00001000);
        issue(enc_j(21'h1ff800, 5'd27), 32'h21c, 4'd6, '0,
              rename_pkg::jal, 1'b1, 1'b0, 1'b0, 32'hfffff800);
        issue(enc_i(12'h004, 5'd5, 3'd0, 5'd28, 7'b1100111), 32'h220, 4'd7, '0,
              rename_pkg::jalr, 1'b1, 1'b1, 1'b0, 32'h00000004);
    endtask

    task automatic test_flush_and_hold();
        rename_pkg::dispatch_entry_t saved;
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd13, 7'b0010011), 32'h300, 4'd1, '0,
              rename_pkg::alu_imm, 1'b1, 1'b1, 1'b0, 32'd1);
        issue(enc_i(12'd2, 5'd0, 3'd0, 5'd14, 7'b0010011), 32'h304, 4'd2, '0,
              rename_pkg::alu_imm, 1'b1, 1'b1, 1'b0, 32'd2);
        // Flush lands together with an accepted instruction.
        @(posedge clk);
        clr        <= 1'b1;
        inst_valid <= 1'b1;
        inst       <= enc_i(12'd3, 5'd0, 3'd0, 5'd15, 7'b0010011);
        pc         <= 32'h3f0;
        alloc_tag  <= 4'd3;
        @(posedge clk);
        clr        <= 1'b0;
        inst_valid <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            m_tag[i] = 4'd0;
        end
        @(negedge clk);
        check_val("dispatch_valid after flush", 32'(dispatch_valid), 32'd0);
        issue(enc_r(7'd0, 5'd14, 5'd13, 3'd0, 5'd16), 32'h308, 4'd3, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
        // Frozen stage offered an instruction for several cycles.
        saved = entry;
        @(posedge clk);
        rdy        <= 1'b0;
        inst_valid <= 1'b1;
        inst       <= enc_i(12'd7, 5'd0, 3'd0, 5'd17, 7'b0010011);
        pc         <= 32'h3f4;
        alloc_tag  <= 4'd7;
        repeat (3) @(posedge clk);
        rdy        <= 1'b1;
        inst_valid <= 1'b0;
        @(negedge clk);
        check_val("dispatch_valid under hold", 32'(dispatch_valid), 32'd0);
        check_val("entry.pc under hold", entry.pc, saved.pc);
        check_val("entry.imm under hold", entry.imm, saved.imm);
        issue(enc_r(7'd0, 5'd0, 5'd17, 3'd0, 5'd18), 32'h30c, 4'd4, '0,
              rename_pkg::alu_reg, 1'b1, 1'b1, 1'b1, 32'h0);
    endtask

    task automatic report();
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        clr        = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        alloc_tag  = '0;
        commit     = '0;
        errors     = 0;
        timeouts   = 0;
        seed       = 42;
        for (int i = 0; i < 32; i++) begin
            m_val[i] = '0;
            m_tag[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset_read();
        test_commit_values();
        test_pending_tag();
        test_commit_bypass();
        test_formats();
        test_flush_and_hold();
        repeat (2) @(posedge clk);
        report();
    end

endmodule

/* src.f */
design/rename_pkg.sv
design/inst_decoder.sv
design/rename_regfile.sv
design/dispatch_merge.sv
design/rename_stage.sv
sim/rename_stage_sva.sv
sim/rename_stage_tb.sv

/* Makefile */
# Verilator build for the rename stage testbench.

VERILATOR ?= verilator
TOP       ?= rename_stage_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) design/*.sv sim/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
